/* compile.f */
+incdir+logic
logic/riscv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/riscv_decode.sv
logic/riscv_regfile.sv
logic/riscv_alu.sv
logic/riscv_pipeline.sv
logic/core_ctrl_regs.sv
logic/riscv_core_top.sv
sim/tb_riscv_core.sv

/* logic/core_ctrl_pkg.sv */
`default_nettype none
`include "core_defs.svh"

package core_ctrl_pkg;

    // Register offsets as seen on paddr
    typedef enum logic [`APB_ADDR_W-1:0] {
        ADDR_CTRL     = `REG_CTRL,
        ADDR_PC       = `REG_PC,
        ADDR_INSTR    = `REG_INSTR,
        ADDR_DBG_SEL  = `REG_DBG_SEL,
        ADDR_DBG_DATA = `REG_DBG_DATA
    } apb_reg_e;

    ////////////////////
    // CTRL register bits
    ////////////////////

    localparam int CTRL_RUN_BIT  = 0;
    localparam int CTRL_STEP_BIT = 1;

endpackage

`default_nettype wire

/* logic/core_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module core_ctrl_regs import core_ctrl_pkg::*; (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire  [`APB_ADDR_W-1:0] paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [`XLEN-1:0]       pwdata,
    output logic [`XLEN-1:0]       prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  wire  [`XLEN-1:0]       pc,
    input  wire  [`XLEN-1:0]       id_instr,
    input  wire  [`XLEN-1:0]       dbg_data,
    output logic [`REG_ADDR_W-1:0] dbg_sel,
    output logic                   advance
);
    logic run;
    logic step_pulse;
    logic access;
    logic mapped;
    logic read_only;
    logic write_ok;

    // No wait states
    assign pready = 1'b1;
    assign access = psel && penable;

    ////////////////////
    // Address decode and readback
    ////////////////////

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (apb_reg_e'(paddr))
            ADDR_CTRL:     prdata[CTRL_RUN_BIT] = run;
            ADDR_PC: begin
                prdata    = pc;
                read_only = 1'b1;
            end
            ADDR_INSTR: begin
                prdata    = id_instr;
                read_only = 1'b1;
            end
            ADDR_DBG_SEL:  prdata = {{(`XLEN-`REG_ADDR_W){1'b0}}, dbg_sel};
            ADDR_DBG_DATA: begin
                prdata    = dbg_data;
                read_only = 1'b1;
            end
            default:       mapped = 1'b0;
        endcase
    end

    assign pslverr  = access && (!mapped || (pwrite && read_only));
    assign write_ok = access && pwrite && !pslverr;

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            run        <= 1'b0;
            step_pulse <= 1'b0;
            dbg_sel    <= '0;
        end else begin
            step_pulse <= 1'b0;
            if (write_ok && paddr == `REG_CTRL) begin
                run <= pwdata[CTRL_RUN_BIT];
                // Step only matters while halted
                step_pulse <= pwdata[CTRL_STEP_BIT] && !pwdata[CTRL_RUN_BIT];
            end
            if (write_ok && paddr == `REG_DBG_SEL) begin
                dbg_sel <= pwdata[`REG_ADDR_W-1:0];
            end
        end
    end

    assign advance = run || step_pulse;

    a_penable_in_sel: assert property (
        @(posedge clk_in) disable iff (rst_in)
        penable |-> psel
    );

    // APB cannot deliver two writes on back-to-back edges
    a_step_one_cycle: assert property (
        @(posedge clk_in) disable iff (rst_in)
        step_pulse |=> !step_pulse
    );

endmodule

`default_nettype wire

/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// First fetch address after reset
`define RESET_PC    32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INSTR   32'h0000_0013

////////////////////
// APB register map
////////////////////

`define APB_ADDR_W    8
`define REG_CTRL      8'h00
`define REG_PC        8'h04
`define REG_INSTR     8'h08
`define REG_DBG_SEL   8'h0C
`define REG_DBG_DATA  8'h10

`endif

/* logic/riscv_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module riscv_alu import riscv_isa_pkg::*; (
    input  wire alu_op_e      op,
    input  wire [`XLEN-1:0]   a,
    input  wire [`XLEN-1:0]   b,
    output logic [`XLEN-1:0]  result
);
    logic [4:0] shamt;

    // Only the low five bits count for shifts
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            ALU_SLTU: begin
                result = '0;
                result[0] = a < b;
            end
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/riscv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module riscv_core_top (
    input  wire                    clk_in,
    input  wire                    rst_in,
    output logic [`XLEN-1:0]       imem_addr,
    input  wire  [`XLEN-1:0]       imem_data,
    input  wire  [`APB_ADDR_W-1:0] paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [`XLEN-1:0]       pwdata,
    output logic [`XLEN-1:0]       prdata,
    output logic                   pready,
    output logic                   pslverr
);
    logic                   advance;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       id_instr;
    logic [`REG_ADDR_W-1:0] dbg_sel;
    logic [`XLEN-1:0]       dbg_data;

    riscv_pipeline u_pipeline (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .advance   (advance),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .pc        (pc),
        .id_instr  (id_instr),
        .dbg_sel   (dbg_sel),
        .dbg_data  (dbg_data)
    );

    // Run, step and debug readback over APB
    core_ctrl_regs u_ctrl (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pc       (pc),
        .id_instr (id_instr),
        .dbg_data (dbg_data),
        .dbg_sel  (dbg_sel),
        .advance  (advance)
    );

endmodule

`default_nettype wire

/* logic/riscv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module riscv_decode import riscv_isa_pkg::*; (
    input  wire instr_u             instr,
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`REG_ADDR_W-1:0]  rd,
    output logic [`XLEN-1:0]        imm,
    output alu_op_e                 alu_op,
    output logic                    use_rs1,
    output logic                    use_rs2,
    output logic                    use_imm,
    output logic                    reg_write
);
    logic    f7_base;
    logic    f7_alt;
    logic    is_op;
    logic    f7_ok;
    logic    writes;
    alu_op_e f3_op;

    assign f7_base = (instr.r.funct7 == F7_BASE);
    assign f7_alt  = (instr.r.funct7 == F7_ALT);
    assign is_op   = (instr.r.opcode == OPC_OP);

    // Register fields share bit positions in every kept format
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    // Operation from funct3, funct7 only qualifies it
    always_comb begin
        f3_op = ALU_ADD;
        f7_ok = is_op ? f7_base : 1'b1;
        case (instr.r.funct3)
            F3_ADD_SUB: begin
                f3_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                f7_ok = !is_op || f7_base || f7_alt;
            end
            F3_SLL: begin
                f3_op = ALU_SLL;
                f7_ok = f7_base;
            end
            F3_SLT:  f3_op = ALU_SLT;
            F3_SLTU: f3_op = ALU_SLTU;
            F3_XOR:  f3_op = ALU_XOR;
            F3_SRL_SRA: begin
                f3_op = f7_alt ? ALU_SRA : ALU_SRL;
                f7_ok = f7_base || f7_alt;
            end
            F3_OR:   f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        imm     = '0;
        alu_op  = f3_op;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        writes  = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                writes  = f7_ok;
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                imm     = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                writes  = f7_ok;
            end
            OPC_LUI: begin
                // Upper 20 bits straight from the word
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
                writes  = 1'b1;
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    assign reg_write = writes && (rd != '0);

endmodule

`default_nettype wire

/* logic/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word seen through either format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* logic/riscv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module riscv_pipeline import riscv_isa_pkg::*; (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    advance,
    input  wire  [`XLEN-1:0]       imem_data,
    output logic [`XLEN-1:0]       imem_addr,
    output logic [`XLEN-1:0]       pc,
    output logic [`XLEN-1:0]       id_instr,
    input  wire  [`REG_ADDR_W-1:0] dbg_sel,
    output logic [`XLEN-1:0]       dbg_data
);
    // Decode outputs
    logic [`REG_ADDR_W-1:0] id_rs1;
    logic [`REG_ADDR_W-1:0] id_rs2;
    logic [`REG_ADDR_W-1:0] id_rd;
    logic [`XLEN-1:0]       id_imm;
    alu_op_e                id_alu_op;
    logic                   id_use_rs1;
    logic                   id_use_rs2;
    logic                   id_use_imm;
    logic                   id_reg_write;
    logic [`XLEN-1:0]       rf_a;
    logic [`XLEN-1:0]       rf_b;
    logic [`XLEN-1:0]       opnd_a;
    logic [`XLEN-1:0]       opnd_b;
    logic                   fwd_a_ex;
    logic                   fwd_a_wb;
    logic                   fwd_b_ex;
    logic                   fwd_b_wb;

    // Execute and writeback stage registers
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic                   ex_reg_write;
    alu_op_e                ex_alu_op;
    logic [`XLEN-1:0]       ex_a;
    logic [`XLEN-1:0]       ex_b;
    logic [`XLEN-1:0]       ex_result;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic                   wb_reg_write;
    logic [`XLEN-1:0]       wb_result;

    ////////////////////
    // Fetch
    ////////////////////

    assign imem_addr = pc;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc       <= `RESET_PC;
            id_instr <= `NOP_INSTR;
        end else if (advance) begin
            pc       <= pc + `XLEN'd4;
            id_instr <= imem_data;
        end
    end

    ////////////////////
    // Decode and operand select
    ////////////////////

    riscv_decode u_decode (
        .instr     (id_instr),
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .rd        (id_rd),
        .imm       (id_imm),
        .alu_op    (id_alu_op),
        .use_rs1   (id_use_rs1),
        .use_rs2   (id_use_rs2),
        .use_imm   (id_use_imm),
        .reg_write (id_reg_write)
    );

    // Written on the same edge that retires the writeback stage
    riscv_regfile u_regfile (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .ra       (id_rs1),
        .rb       (id_rs2),
        .wa       (wb_rd),
        .dbg_sel  (dbg_sel),
        .wd       (wb_result),
        .we       (wb_reg_write && advance),
        .rd_a     (rf_a),
        .rd_b     (rf_b),
        .dbg_data (dbg_data)
    );

    // reg_write is never set for x0, so x0 is never forwarded
    assign fwd_a_ex = id_use_rs1 && ex_reg_write && (ex_rd == id_rs1);
    assign fwd_a_wb = id_use_rs1 && wb_reg_write && (wb_rd == id_rs1);
    assign fwd_b_ex = id_use_rs2 && ex_reg_write && (ex_rd == id_rs2);
    assign fwd_b_wb = id_use_rs2 && wb_reg_write && (wb_rd == id_rs2);

    // Youngest producer wins
    always_comb begin
        if (!id_use_rs1) begin
            opnd_a = '0;
        end else if (fwd_a_ex) begin
            opnd_a = ex_result;
        end else if (fwd_a_wb) begin
            opnd_a = wb_result;
        end else begin
            opnd_a = rf_a;
        end

        if (id_use_imm) begin
            opnd_b = id_imm;
        end else if (fwd_b_ex) begin
            opnd_b = ex_result;
        end else if (fwd_b_wb) begin
            opnd_b = wb_result;
        end else begin
            opnd_b = rf_b;
        end
    end

    ////////////////////
    // Execute and writeback
    ////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ex_reg_write <= 1'b0;
            wb_reg_write <= 1'b0;
        end else if (advance) begin
            ex_reg_write <= id_reg_write;
            wb_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk_in) begin
        if (advance) begin
            ex_rd     <= id_rd;
            ex_alu_op <= id_alu_op;
            ex_a      <= opnd_a;
            ex_b      <= opnd_b;
            wb_rd     <= ex_rd;
            wb_result <= ex_result;
        end
    end

    riscv_alu u_alu (
        .op     (ex_alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result)
    );

    a_pc_aligned: assert property (
        @(posedge clk_in) disable iff (rst_in)
        pc[1:0] == 2'b00
    );

    // Whole pipeline freezes between control-block pulses
    a_hold_when_idle: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !advance |=> $stable(pc) && $stable(id_instr) &&
                     $stable(ex_reg_write) && $stable(wb_reg_write)
    );

endmodule

`default_nettype wire

/* logic/riscv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module riscv_regfile (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire  [`REG_ADDR_W-1:0] ra,
    input  wire  [`REG_ADDR_W-1:0] rb,
    input  wire  [`REG_ADDR_W-1:0] wa,
    input  wire  [`REG_ADDR_W-1:0] dbg_sel,
    input  wire  [`XLEN-1:0]       wd,
    input  wire                    we,
    output logic [`XLEN-1:0]       rd_a,
    output logic [`XLEN-1:0]       rd_b,
    output logic [`XLEN-1:0]       dbg_data
);
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero on every port
    assign rd_a     = (ra == '0) ? '0 : regs[ra];
    assign rd_b     = (rb == '0) ? '0 : regs[rb];
    assign dbg_data = (dbg_sel == '0) ? '0 : regs[dbg_sel];

    // Decoder never lets an x0 destination reach writeback
    a_no_x0_write: assert property (
        @(posedge clk_in) disable iff (rst_in)
        we |-> wa != '0
    );

endmodule

`default_nettype wire

/* sim/tb_riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module tb_riscv_core;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int ROM_WORDS       = 64;
    localparam int PROG_MAX        = 40;
    localparam int XFER_CYCLES     = 3;
    localparam int READBACK_CYCLES = 64 * XFER_CYCLES;
    localparam int RUN_CYCLES      = PROG_MAX + 4 + 4 * XFER_CYCLES;
    localparam int TEST_CYCLES     = 6 * (RESET_CYCLES + 2) + 60 * XFER_CYCLES + 20
                                     + 3 * (RUN_CYCLES + READBACK_CYCLES);

    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_UPPER = 7'b0110111;
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;

    logic                   clk_in;
    logic                   rst_in;
    logic [`XLEN-1:0]       imem_addr;
    logic [`XLEN-1:0]       imem_data;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`XLEN-1:0]       pwdata;
    logic [`XLEN-1:0]       prdata;
    logic                   pready;
    logic                   pslverr;

    logic [`XLEN-1:0] rom      [ROM_WORDS];
    logic [`XLEN-1:0] ref_regs [32];
    int               prog_len;
    int               error_count;
    logic [31:0]      lcg_state;

    riscv_core_top DUT (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // Combinational instruction ROM, NOPs past the end
    assign imem_data = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[7:2]] : `NOP_INSTR;

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within the cycle limit");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s got %h expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return r[20:16];
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = lcg_next();
        return r[27:16];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_UPPER};
    endfunction

    // Random upper fields under a given opcode
    function automatic logic [31:0] enc_unsupported(input logic [6:0] opc,
                                                    input logic [4:0] rd);
        logic [31:0] r;
        r = lcg_next();
        return {r[31:12], rd, opc};
    endfunction

    // RV32I integer semantics by funct3
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] res;
        sh = b[4:0];
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << sh;
            3'b010:  res = {31'd0, $signed(a) < $signed(b)};
            3'b011:  res = {31'd0, a < b};
            3'b100:  res = a ^ b;
            3'b101: begin
                if (alt) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic ref_exec(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        rd  = ins[11:7];
        f3  = ins[14:12];
        a   = ref_regs[ins[19:15]];
        b   = ref_regs[ins[24:20]];
        res = '0;
        wr  = 1'b1;
        case (ins[6:0])
            OPC_REG: res = alu_model(f3, ins[30], a, b);
            OPC_IMM: begin
                b   = {{20{ins[31]}}, ins[31:20]};
                // Bit 30 only selects SRAI among immediates
                res = alu_model(f3, ins[30] && (f3 == 3'b101), a, b);
            end
            OPC_UPPER: res = {ins[31:12], 12'h000};
            default:   wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            ref_regs[rd] = res;
        end
    endtask

    task automatic add_instr(input logic [31:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        rst_in  <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
    endtask

    // Fresh ROM, fresh model state, core in reset
    task automatic prepare_test();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = `NOP_INSTR;
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        prog_len = 0;
        apply_reset();
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk_in);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_in);
        penable <= 1'b1;
        @(negedge clk_in);
        check_value("pready", pready, 1);
        err = pslverr;
        @(posedge clk_in);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_in);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_in);
        penable <= 1'b1;
        @(negedge clk_in);
        check_value("pready", pready, 1);
        data = prdata;
        err  = pslverr;
        @(posedge clk_in);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic compare_all_regs();
        logic [31:0] data;
        logic        err;
        for (int r = 0; r < 32; r++) begin
            apb_write(`REG_DBG_SEL, r, err);
            apb_read(`REG_DBG_DATA, data, err);
            check_value($sformatf("dbg_data x%0d", r), data, ref_regs[r]);
        end
    endtask

    // Run bit set for exactly the given number of advances
    task automatic run_and_compare(input int advances);
        logic [31:0] data;
        logic        err;
        apb_write(`REG_CTRL, 32'h1, err);
        check_value("pslverr", err, 0);
        repeat (advances - 3) @(posedge clk_in);
        apb_write(`REG_CTRL, 32'h0, err);
        for (int i = 0; i < advances - 3; i++) begin
            ref_exec(rom[i]);
        end
        apb_read(`REG_PC, data, err);
        check_value("pc", data, `RESET_PC + 4 * advances);
        compare_all_regs();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic check_reset_state();
        logic [31:0] data;
        logic        err;
        prepare_test();
        apb_read(`REG_PC, data, err);
        check_value("pc", data, `RESET_PC);
        check_value("pslverr", err, 0);
        apb_read(`REG_INSTR, data, err);
        check_value("instr", data, `NOP_INSTR);
        apb_read(`REG_CTRL, data, err);
        check_value("ctrl", data, 0);
        repeat (10) @(posedge clk_in);
        apb_read(`REG_PC, data, err);
        check_value("pc", data, `RESET_PC);
    endtask

    task automatic step_one_at_a_time();
        logic [31:0] data;
        logic [31:0] exp_pc;
        logic        err;
        prepare_test();
        for (int i = 0; i < 16; i++) begin
            rom[i] = lcg_next();
        end
        exp_pc = `RESET_PC;
        for (int i = 0; i < 8; i++) begin
            apb_write(`REG_CTRL, 32'h2, err);
            check_value("pslverr", err, 0);
            apb_read(`REG_PC, data, err);
            check_value("pc", data, exp_pc + 4);
            apb_read(`REG_INSTR, data, err);
            check_value("instr", data, rom[exp_pc[7:2]]);
            exp_pc = exp_pc + 4;
        end
        // Step bit is write-only
        apb_read(`REG_CTRL, data, err);
        check_value("ctrl", data, 0);
    endtask

    task automatic run_random_program();
        logic [4:0]  sh;
        logic [11:0] hi;
        logic [11:0] lo;
        prepare_test();
        for (int k = 0; k < 6; k++) begin
            add_instr(enc_i(rand_imm(), 5'd0, 3'b000, rand_reg()));
        end
        for (int k = 0; k < 2; k++) begin
            hi = rand_imm();
            lo = rand_imm();
            add_instr(enc_u({hi, lo[7:0]}, rand_reg()));
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            add_instr(enc_r(F7_BASE, rand_reg(), rand_reg(), f3[2:0], rand_reg()));
        end
        add_instr(enc_r(F7_ALT, rand_reg(), rand_reg(), 3'b000, rand_reg()));
        add_instr(enc_r(F7_ALT, rand_reg(), rand_reg(), 3'b101, rand_reg()));
        // ADDI, SLTI, SLTIU, XORI
        for (int f3 = 0; f3 < 5; f3++) begin
            if (f3 != 1) begin
                add_instr(enc_i(rand_imm(), rand_reg(), f3[2:0], rand_reg()));
            end
        end
        add_instr(enc_i(rand_imm(), rand_reg(), 3'b110, rand_reg()));
        add_instr(enc_i(rand_imm(), rand_reg(), 3'b111, rand_reg()));
        sh = rand_reg();
        add_instr(enc_i({F7_BASE, sh}, rand_reg(), 3'b001, rand_reg()));
        add_instr(enc_i({F7_BASE, rand_reg()}, rand_reg(), 3'b101, rand_reg()));
        add_instr(enc_i({F7_ALT, rand_reg()}, rand_reg(), 3'b101, rand_reg()));
        run_and_compare(prog_len + 4);
    endtask

    // Every instruction consumes the one just before it
    task automatic run_dependent_chain();
        prepare_test();
        add_instr(enc_i(rand_imm(), 5'd0, 3'b000, 5'd5));
        add_instr(enc_i(rand_imm(), 5'd5, 3'b000, 5'd6));
        add_instr(enc_r(F7_BASE, 5'd5, 5'd6, 3'b000, 5'd7));
        add_instr(enc_r(F7_ALT, 5'd6, 5'd7, 3'b000, 5'd8));
        add_instr(enc_u({rand_imm(), 8'h5a}, 5'd9));
        add_instr(enc_r(F7_BASE, 5'd8, 5'd9, 3'b110, 5'd10));
        add_instr(enc_r(F7_ALT, 5'd8, 5'd10, 3'b101, 5'd11));
        add_instr(enc_i(rand_imm(), 5'd11, 3'b100, 5'd12));
        add_instr(enc_r(F7_BASE, 5'd11, 5'd12, 3'b010, 5'd13));
        // Same rd twice, youngest value must win
        add_instr(enc_i(12'd1, 5'd0, 3'b000, 5'd14));
        add_instr(enc_i(12'd2, 5'd0, 3'b000, 5'd14));
        add_instr(enc_r(F7_BASE, 5'd14, 5'd14, 3'b000, 5'd15));
        add_instr(enc_r(F7_BASE, 5'd13, 5'd15, 3'b001, 5'd16));
        add_instr(enc_r(F7_BASE, 5'd16, 5'd12, 3'b011, 5'd17));
        run_and_compare(prog_len + 4);
    endtask

    task automatic x0_and_unsupported();
        prepare_test();
        add_instr(enc_i(12'h123, 5'd0, 3'b000, 5'd1));
        add_instr(enc_i(12'h555, 5'd0, 3'b000, 5'd0));
        add_instr(enc_u(20'habcde, 5'd0));
        add_instr(enc_r(F7_BASE, 5'd1, 5'd1, 3'b000, 5'd0));
        add_instr(enc_r(F7_BASE, 5'd1, 5'd0, 3'b000, 5'd2));
        // Load, store, branch, JAL, JALR, AUIPC
        add_instr(enc_unsupported(7'b0000011, 5'd1));
        add_instr(enc_unsupported(7'b0100011, 5'd2));
        add_instr(enc_unsupported(7'b1100011, 5'd1));
        add_instr(enc_unsupported(7'b1101111, 5'd1));
        add_instr(enc_unsupported(7'b1100111, 5'd2));
        add_instr(enc_unsupported(7'b0010111, 5'd3));
        add_instr(enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd4));
        run_and_compare(prog_len + 4);
    endtask

    task automatic apb_error_responses();
        logic [31:0] data;
        logic        err;
        prepare_test();
        apb_read(8'h14, data, err);
        check_value("pslverr", err, 1);
        apb_write(8'h20, 32'h1, err);
        check_value("pslverr", err, 1);
        apb_write(`REG_PC, 32'h100, err);
        check_value("pslverr", err, 1);
        apb_write(`REG_INSTR, 32'hffff_ffff, err);
        check_value("pslverr", err, 1);
        apb_write(`REG_DBG_DATA, 32'h1234_5678, err);
        check_value("pslverr", err, 1);
        repeat (5) @(posedge clk_in);
        apb_read(`REG_PC, data, err);
        check_value("pc", data, `RESET_PC);
        check_value("pslverr", err, 0);
        apb_read(`REG_INSTR, data, err);
        check_value("instr", data, `NOP_INSTR);
        apb_read(`REG_CTRL, data, err);
        check_value("ctrl", data, 0);
        apb_read(`REG_DBG_SEL, data, err);
        check_value("dbg_sel", data, 0);
        apb_write(`REG_DBG_SEL, 32'h5, err);
        check_value("pslverr", err, 0);
        apb_read(`REG_DBG_SEL, data, err);
        check_value("dbg_sel", data, 32'h5);
        check_value("pslverr", err, 0);
    endtask

    initial begin
        rst_in      = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        lcg_state   = 32'd60;
        error_count = 0;
        prog_len    = 0;
        check_reset_state();
        step_one_at_a_time();
        run_random_program();
        run_dependent_chain();
        x0_and_unsupported();
        apb_error_responses();
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
